// File: Makefile
# Verilator build and run of the execution cluster testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_exu -f vlog.f

run: build
	obj_dir/Vtb_exu | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module tb_exu -f vlog.f

clean:
	rm -rf obj_dir $(LOG)

// File: tests/exu_model.svh
// ~~~~~~~~~~~~~~~~~~~~
// Expected ALU results and the result bus history
// ~~~~~~~~~~~~~~~~~~~~

`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

  exu_pkg::result_bus_t hist_now;
  exu_pkg::result_bus_t hist_prev;
  // Result of the operation sampled at the latest edge
  exu_pkg::result_bus_t hist_next;

  function automatic exu_pkg::lane_result_t alu_expect(input exu_pkg::issue_t s,
      input logic [63:0] a, input logic [63:0] b, input bit has_shift);
    exu_pkg::lane_result_t r;
    logic [63:0]           mask;
    logic [63:0]           ua;
    logic [63:0]           ub;
    logic [64:0]           sum;
    logic [64:0]           sa;
    logic [64:0]           sb;
    logic [64:0]           exact;
    logic [64:0]           trunc;
    logic signed [63:0]    sx;
    logic [5:0]            amt;
    int                    top;
    r = '0;
    if (!s.valid) begin
      return r;
    end
    r.valid = 1'b1;
    r.tag = s.tag;
    if (!has_shift && s.op inside {exu_pkg::op_shl, exu_pkg::op_shr, exu_pkg::op_sar}) begin
      r.flags.illegal = 1'b1;
      return r;
    end
    r.writes = (s.op != exu_pkg::op_cmp);
    top = s.w32 ? 31 : 63;
    mask = s.w32 ? 64'hffff_ffff : '1;
    ua = a & mask;
    ub = b & mask;
    // Sign-extended past the top bit so the exact signed result fits
    sa = s.w32 ? {{33{a[31]}}, a[31:0]} : {a[63], a};
    sb = s.w32 ? {{33{b[31]}}, b[31:0]} : {b[63], b};
    exact = '0;
    amt = b[5:0] & (s.w32 ? 6'd31 : 6'd63);
    sx = s.w32 ? {{32{a[31]}}, a[31:0]} : a;
    case (s.op)
      exu_pkg::op_add: begin
        sum = {1'b0, ua} + {1'b0, ub};
        r.data = sum[63:0] & mask;
        r.flags.carry = sum[top + 1];
        exact = sa + sb;
      end
      // Carry means borrow here
      exu_pkg::op_sub, exu_pkg::op_cmp: begin
        r.data = (ua - ub) & mask;
        r.flags.carry = (ua < ub);
        exact = sa - sb;
      end
      exu_pkg::op_and: r.data = a & b & mask;
      exu_pkg::op_or:  r.data = (a | b) & mask;
      exu_pkg::op_xor: r.data = (a ^ b) & mask;
      exu_pkg::op_shl: r.data = (ua << amt) & mask;
      exu_pkg::op_shr: r.data = ua >> amt;
      default: begin
        sx = sx >>> amt;
        r.data = sx & mask;
      end
    endcase
    // Overflow when truncation changes the exact signed result
    if (s.op inside {exu_pkg::op_add, exu_pkg::op_sub, exu_pkg::op_cmp}) begin
      trunc = s.w32 ? {{33{r.data[31]}}, r.data[31:0]} : {r.data[63], r.data};
      r.flags.overflow = (exact != trunc);
    end
    r.flags.zero = (r.data == '0);
    r.flags.sign = r.data[top];
    return r;
  endfunction

  // Buses before the edge feed the operands of the operation sampled at it
  task automatic advance_history(input exu_pkg::issue_t [`EXU_LANES-1:0] s);
    exu_pkg::result_bus_t nxt;
    logic [63:0]          a;
    logic [63:0]          b;
    for (int l = 0; l < `EXU_LANES; l++) begin
      a = (s[l].a_sel == exu_pkg::from_bus_now)  ? hist_now[s[l].a_bus].data :
          (s[l].a_sel == exu_pkg::from_bus_prev) ? hist_prev[s[l].a_bus].data : s[l].a;
      b = (s[l].b_sel == exu_pkg::from_bus_now)  ? hist_now[s[l].b_bus].data :
          (s[l].b_sel == exu_pkg::from_bus_prev) ? hist_prev[s[l].b_bus].data : s[l].b;
      nxt[l] = alu_expect(s[l], a, b, l != 0);
    end
    hist_prev = hist_now;
    hist_now = hist_next;
    hist_next = nxt;
  endtask

`endif

// File: tests/tb_exu.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the execution cluster, LFSR stimulus against the model
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "exu_defines.svh"

module tb_exu;

  localparam int CYCLES = 2000;

  logic                             clk;
  logic                             arst_n;
  exu_pkg::issue_t [`EXU_LANES-1:0] issue;
  exu_pkg::result_bus_t             result;
  exu_pkg::issue_t [`EXU_LANES-1:0] drv;
  exu_pkg::issue_t [`EXU_LANES-1:0] src_now;
  exu_pkg::issue_t [`EXU_LANES-1:0] src_next;
  logic [31:0]                      lfsr_state;
  logic [63:0]                      r;
  int                               checks;
  int                               mismatches;

  `include "exu_model.svh"

  exu_top exu_top_i (.clk(clk), .arst_n(arst_n), .issue(issue), .result(result));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic exu_pkg::fwd_sel_e sel_from_bits(input logic [1:0] bits);
    return (bits == 2'd3) ? exu_pkg::from_port : exu_pkg::fwd_sel_e'(bits);
  endfunction

  function automatic exu_pkg::issue_t random_issue();
    exu_pkg::issue_t s;
    logic [63:0]     v;
    v = rand_bits(20);
    s.valid = (v[2:0] != 3'd0);
    s.op = exu_pkg::alu_op_e'(v[6:3] % 4'd9);
    s.w32 = v[7];
    s.a_sel = sel_from_bits(v[9:8]);
    s.a_bus = v[10];
    s.b_sel = sel_from_bits(v[12:11]);
    s.b_bus = v[13];
    s.tag = v[19:14];
    s.a = rand_bits(64);
    s.b = rand_bits(64);
    v = rand_bits(3);
    // Equal operands now and then for zero results
    if (v[2:0] == 3'd0) begin
      s.b = s.a;
    end
    return s;
  endfunction

  function automatic string test_name(input exu_pkg::issue_t s, input int lane);
    if (!s.valid) return "idle";
    if (s.a_sel != exu_pkg::from_port || s.b_sel != exu_pkg::from_port) return "forward";
    if (s.op == exu_pkg::op_cmp) return "compare";
    if (s.op inside {exu_pkg::op_shl, exu_pkg::op_shr, exu_pkg::op_sar}) begin
      return (lane == 0) ? "shift_illegal" : "shift";
    end
    return "arith_logic";
  endfunction

  task automatic check_buses(input bit in_reset);
    exu_pkg::lane_result_t exp;
    exu_pkg::lane_result_t got;
    for (int l = 0; l < `EXU_LANES; l++) begin
      exp = hist_now[l];
      if (in_reset) begin
        exp = '0;
      end
      got = result[l];
      // Compare data is not architectural
      if (src_now[l].valid && src_now[l].op == exu_pkg::op_cmp) begin
        exp.data = '0;
        got.data = '0;
      end
      checks++;
      if (got !== exp) begin
        mismatches++;
        $display("mismatch %s lane %0d: expected %h, actual %h",
                 in_reset ? "reset" : test_name(src_now[l], l), l, exp, got);
      end
    end
  endtask

  initial begin
    lfsr_state = 32'h0c252ddd;
    checks = 0;
    mismatches = 0;
    hist_now = '0;
    hist_prev = '0;
    hist_next = '0;
    drv = '0;
    src_now = '0;
    src_next = '0;
    arst_n <= 1'b0;
    issue <= '0;
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_buses(1'b1);
    end
    @(posedge clk);
    arst_n <= 1'b1;
    // Last two cycles drain both lanes
    for (int c = 0; c < CYCLES + 2; c++) begin
      @(posedge clk);
      advance_history(drv);
      src_now = src_next;
      src_next = drv;
      for (int l = 0; l < `EXU_LANES; l++) begin
        drv[l] = random_issue();
      end
      r = rand_bits(4);
      if (c >= CYCLES || r[3:0] == 4'd0) begin
        drv[0].valid = 1'b0;
        drv[1].valid = 1'b0;
      end
      issue <= drv;
      @(negedge clk);
      check_buses(1'b0);
    end
    $display("checks %0d, mismatches %0d", checks, mismatches);
    if (mismatches == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #((CYCLES + 50) * 10);
    $display("watchdog expired before the test sequence finished");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: verilog/alu_lane.sv
// ~~~~~~~~~~~~~~~~~~~~
// Adder, logic unit, optional shifter and flags for one lane
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "exu_defines.svh"

module alu_lane #(
  parameter int HAS_SHIFT = 1
) (
  input  exu_pkg::alu_ctrl_t     ctrl,
  input  logic [`EXU_DATA_W-1:0] a,
  input  logic [`EXU_DATA_W-1:0] b,
  output exu_pkg::lane_result_t  result
);

  localparam int W    = `EXU_DATA_W;
  localparam int H    = `EXU_HALF_W;
  localparam int SH_W = $clog2(W);

  logic [W-1:0] b_eff;
  logic [W:0]   sum_full;
  logic [H:0]   sum_half;
  logic [W-1:0] add_res;
  logic         add_cout;
  logic         add_ovf;
  logic [W-1:0] logic_res;
  logic [W-1:0] shift_res;
  logic [W-1:0] res;
  logic         is_arith;

  // ~~~~~~~~~~~~~~~~~~~~
  // Adder, B inverted with carry in for sub and cmp
  assign b_eff    = ctrl.sub ? ~b : b;
  assign sum_full = {1'b0, a} + {1'b0, b_eff} + {{W{1'b0}}, ctrl.sub};
  assign sum_half = {1'b0, a[H-1:0]} + {1'b0, b_eff[H-1:0]} + {{H{1'b0}}, ctrl.sub};

  always_comb begin
    if (ctrl.w32) begin
      add_res  = {{(W-H){1'b0}}, sum_half[H-1:0]};
      add_cout = sum_half[H];
      add_ovf  = (a[H-1] == b_eff[H-1]) && (sum_half[H-1] != a[H-1]);
    end else begin
      add_res  = sum_full[W-1:0];
      add_cout = sum_full[W];
      add_ovf  = (a[W-1] == b_eff[W-1]) && (sum_full[W-1] != a[W-1]);
    end
  end

  always_comb begin
    case (ctrl.logic_sel)
      exu_pkg::lsel_and: logic_res = a & b;
      exu_pkg::lsel_or:  logic_res = a | b;
      exu_pkg::lsel_xor: logic_res = a ^ b;
      default:           logic_res = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Barrel shifter, amount is b modulo the width
  if (HAS_SHIFT != 0) begin : g_shift
    logic [SH_W-1:0] amt;
    logic [W-1:0]    sh_in;
    logic [2*W-1:0]  wide;
    logic            fill;

    assign fill  = ctrl.shift_arith & (ctrl.w32 ? a[H-1] : a[W-1]);
    assign amt   = ctrl.w32 ? {1'b0, b[SH_W-2:0]} : b[SH_W-1:0];
    // 32-bit form extends the low half so a full-width shift works
    assign sh_in = ctrl.w32 ? {{(W-H){fill}}, a[H-1:0]} : a;
    assign wide  = {{W{fill}}, sh_in} >> amt;

    always_comb begin
      if (ctrl.shift_right) begin
        shift_res = wide[W-1:0];
      end else begin
        shift_res = sh_in << amt;
      end
    end
  end else begin : g_no_shift
    assign shift_res = '0;
  end

  assign is_arith = !ctrl.is_shift && (ctrl.logic_sel == exu_pkg::lsel_none);

  always_comb begin
    if (ctrl.is_shift) begin
      res = shift_res;
    end else if (!is_arith) begin
      res = logic_res;
    end else begin
      res = add_res;
    end
    if (ctrl.w32) begin
      res[W-1:H] = '0;
    end
  end

  // Idle cycles put an all-zero result on the bus
  always_comb begin
    result       = '0;
    result.valid = ctrl.valid;
    if (ctrl.valid) begin
      result.tag = ctrl.tag;
      if (ctrl.illegal) begin
        result.flags.illegal = 1'b1;
      end else begin
        result.writes         = ctrl.writes;
        result.data           = res;
        result.flags.zero     = (res == '0);
        result.flags.sign     = ctrl.w32 ? res[H-1] : res[W-1];
        // Borrow is the inverted carry out of a + ~b + 1
        result.flags.carry    = is_arith & (add_cout ^ ctrl.sub);
        result.flags.overflow = is_arith & add_ovf;
      end
    end
  end

endmodule

// File: verilog/exu_defines.svh
// ~~~~~~~~~~~~~~~~~~~~
// Widths and counts for the integer execution cluster
// ~~~~~~~~~~~~~~~~~~~~

`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// Operand and result width
`define EXU_DATA_W 64
// Width of the 32-bit forms
`define EXU_HALF_W 32

// Destination tag
`define EXU_TAG_W 6

// Lanes, one result bus each
`define EXU_LANES 2
`define EXU_LANE_IDX_W 1

`endif

// File: verilog/exu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Opcode, source select and lane enums, issue/control/result structs
// ~~~~~~~~~~~~~~~~~~~~

`include "exu_defines.svh"

package exu_pkg;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_cmp = 4'd5,
    op_shl = 4'd6,
    op_shr = 4'd7,
    op_sar = 4'd8
  } alu_op_e;

  // Operand source, age is relative to the sampling edge
  typedef enum logic [1:0] {
    from_port     = 2'd0,
    from_bus_now  = 2'd1,
    from_bus_prev = 2'd2
  } fwd_sel_e;

  // Adder path when none
  typedef enum logic [1:0] {
    lsel_none = 2'd0,
    lsel_and  = 2'd1,
    lsel_or   = 2'd2,
    lsel_xor  = 2'd3
  } logic_sel_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // Issue side

  typedef struct packed {
    logic                        valid;
    alu_op_e                     op;
    logic                        w32;
    logic [`EXU_DATA_W-1:0]      a;
    logic [`EXU_DATA_W-1:0]      b;
    fwd_sel_e                    a_sel;
    logic [`EXU_LANE_IDX_W-1:0]  a_bus;
    fwd_sel_e                    b_sel;
    logic [`EXU_LANE_IDX_W-1:0]  b_bus;
    logic [`EXU_TAG_W-1:0]       tag;
  } issue_t;

  typedef struct packed {
    logic                  valid;
    logic                  sub;
    logic_sel_e            logic_sel;
    logic                  is_shift;
    logic                  shift_right;
    logic                  shift_arith;
    logic                  w32;
    logic                  writes;
    logic                  illegal;
    logic [`EXU_TAG_W-1:0] tag;
  } alu_ctrl_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Result side

  typedef struct packed {
    logic zero;
    logic carry;
    logic sign;
    logic overflow;
    logic illegal;
  } alu_flags_t;

  typedef struct packed {
    logic                   valid;
    logic                   writes;
    logic [`EXU_DATA_W-1:0] data;
    alu_flags_t             flags;
    logic [`EXU_TAG_W-1:0]  tag;
  } lane_result_t;

  typedef lane_result_t [`EXU_LANES-1:0] result_bus_t;

endpackage

// File: verilog/exu_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Two ALU lanes sharing their result buses for forwarding
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "exu_defines.svh"

module exu_top (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  exu_pkg::issue_t [`EXU_LANES-1:0]     issue,
  output exu_pkg::result_bus_t                 result
);

  exu_pkg::result_bus_t                     bus_now;
  exu_pkg::result_bus_t                     bus_prev;
  exu_pkg::alu_ctrl_t [`EXU_LANES-1:0]      ctrl;
  exu_pkg::lane_result_t [`EXU_LANES-1:0]   lane_out;
  logic [`EXU_LANES-1:0][`EXU_DATA_W-1:0]   opa;
  logic [`EXU_LANES-1:0][`EXU_DATA_W-1:0]   opb;

  // Lane 0 has no shifter
  for (genvar l = 0; l < `EXU_LANES; l++) begin : g_lane
    operand_fwd a_fwd_i (
      .clk(clk), .arst_n(arst_n), .en(issue[l].valid),
      .port_data(issue[l].a), .sel(issue[l].a_sel), .bus_idx(issue[l].a_bus),
      .bus_now(bus_now), .bus_prev(bus_prev), .operand(opa[l])
    );

    operand_fwd b_fwd_i (
      .clk(clk), .arst_n(arst_n), .en(issue[l].valid),
      .port_data(issue[l].b), .sel(issue[l].b_sel), .bus_idx(issue[l].b_bus),
      .bus_now(bus_now), .bus_prev(bus_prev), .operand(opb[l])
    );

    op_decode #(.HAS_SHIFT((l == 0) ? 0 : 1)) dec_i (
      .clk(clk), .arst_n(arst_n), .issue(issue[l]), .ctrl(ctrl[l])
    );

    alu_lane #(.HAS_SHIFT((l == 0) ? 0 : 1)) alu_i (
      .ctrl(ctrl[l]), .a(opa[l]), .b(opb[l]), .result(lane_out[l])
    );

    result_bus bus_i (
      .clk(clk), .arst_n(arst_n), .lane_in(lane_out[l]),
      .bus_now(bus_now[l]), .bus_prev(bus_prev[l])
    );
  end

  assign result = bus_now;

endmodule

// File: verilog/op_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// Opcode decode into registered ALU controls
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module op_decode #(
  parameter int HAS_SHIFT = 1
) (
  input  logic               clk,
  input  logic               arst_n,
  input  exu_pkg::issue_t    issue,
  output exu_pkg::alu_ctrl_t ctrl
);

  exu_pkg::alu_ctrl_t dec;

  always_comb begin
    dec           = '0;
    dec.valid     = issue.valid;
    dec.w32       = issue.w32;
    dec.tag       = issue.tag;
    dec.writes    = 1'b1;
    dec.logic_sel = exu_pkg::lsel_none;
    case (issue.op)
      exu_pkg::op_add: dec.sub = 1'b0;
      exu_pkg::op_sub: dec.sub = 1'b1;
      // Flags only, no register write
      exu_pkg::op_cmp: begin
        dec.sub    = 1'b1;
        dec.writes = 1'b0;
      end
      exu_pkg::op_and: dec.logic_sel = exu_pkg::lsel_and;
      exu_pkg::op_or:  dec.logic_sel = exu_pkg::lsel_or;
      exu_pkg::op_xor: dec.logic_sel = exu_pkg::lsel_xor;
      exu_pkg::op_shl: dec.is_shift = 1'b1;
      exu_pkg::op_shr: begin
        dec.is_shift    = 1'b1;
        dec.shift_right = 1'b1;
      end
      exu_pkg::op_sar: begin
        dec.is_shift    = 1'b1;
        dec.shift_right = 1'b1;
        dec.shift_arith = 1'b1;
      end
      default: dec.illegal = 1'b1;
    endcase

    // No barrel shifter on this lane
    if (dec.is_shift && HAS_SHIFT == 0) begin
      dec.illegal = 1'b1;
    end
    if (dec.illegal) begin
      dec.writes = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= '0;
    end else begin
      ctrl <= dec;
    end
  end

endmodule

// File: verilog/operand_fwd.sv
// ~~~~~~~~~~~~~~~~~~~~
// Source operand pick from issue port or result bus, current or older age
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "exu_defines.svh"

module operand_fwd (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       en,
  input  logic [`EXU_DATA_W-1:0]     port_data,
  input  exu_pkg::fwd_sel_e          sel,
  input  logic [`EXU_LANE_IDX_W-1:0] bus_idx,
  input  exu_pkg::result_bus_t       bus_now,
  input  exu_pkg::result_bus_t       bus_prev,
  output logic [`EXU_DATA_W-1:0]     operand
);

  logic [`EXU_DATA_W-1:0] picked;

  // Bus data is taken whether or not the bus was valid
  always_comb begin
    case (sel)
      exu_pkg::from_bus_now:  picked = bus_now[bus_idx].data;
      exu_pkg::from_bus_prev: picked = bus_prev[bus_idx].data;
      default:                picked = port_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (en) begin
      operand <= picked;
    end
  end

  // Issue logic must never send an unknown source code
  a_sel_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    en |-> sel inside {exu_pkg::from_port, exu_pkg::from_bus_now, exu_pkg::from_bus_prev}
  );

endmodule

// File: verilog/result_bus.sv
// ~~~~~~~~~~~~~~~~~~~~
// Lane result register and its one-cycle-older copy
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module result_bus (
  input  logic                  clk,
  input  logic                  arst_n,
  input  exu_pkg::lane_result_t lane_in,
  output exu_pkg::lane_result_t bus_now,
  output exu_pkg::lane_result_t bus_prev
);

  // bus_prev feeds the older forwarding age
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_now  <= '0;
      bus_prev <= '0;
    end else begin
      bus_now  <= lane_in;
      bus_prev <= bus_now;
    end
  end

  // Write enable comes from decode and must ride with a valid result
  writes_needs_valid: assert property (
    @(posedge clk) disable iff (!arst_n)
    bus_now.writes |-> bus_now.valid
  );

  held_in_reset: assert property (
    @(posedge clk)
    !arst_n |-> (bus_now == '0 && bus_prev == '0)
  );

endmodule

// File: vlog.f
+incdir+verilog
+incdir+tests
verilog/exu_pkg.sv
verilog/operand_fwd.sv
verilog/op_decode.sv
verilog/alu_lane.sv
verilog/result_bus.sv
verilog/exu_top.sv
tests/tb_exu.sv
